// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^$(PASS_MSG)$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Machine word, also the byte address width
    localparam int XLEN = 32;

    // Instruction width, no compressed forms
    localparam int ILEN = 32;

    // Bus addresses count words, byte offset dropped
    localparam int WADR_W = XLEN - 2;

    // Interrupt cause selects one of eight table entries
    localparam int CAUSE_W = 3;

    // Default table location, top eight words of a 256-word memory
    // Entry 0 holds the reset vector, entry n the handler for cause n
    localparam logic [XLEN-1:0] VTABLE_BASE = 32'h0000_03e0;

    // Prefetch bus states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        VECTOR = 2'd1,
        FETCH  = 2'd2
    } prefetch_state_t;

endpackage

`default_nettype wire

// File: list.f
common/fetch_pkg.sv
prefetch/fetch_prefetch.sv
source/pc_sequencer.sv
source/wb_arbiter.sv
source/wb_imem.sv
source/fetch_top.sv
test/fetch_chk.sv
test/fetch_tb.sv

// File: prefetch/fetch_prefetch.sv
`default_nettype none

module fetch_prefetch #(
    parameter logic [fetch_pkg::XLEN-1:0] VTABLE_BASE = fetch_pkg::VTABLE_BASE
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        advance_i,
    input  logic [fetch_pkg::XLEN-1:0]    pc_i,
    input  logic                        irq_i,
    input  logic [fetch_pkg::CAUSE_W-1:0] irq_cause_i,
    input  logic                        grant_i,
    input  logic [fetch_pkg::XLEN-1:0]    dat_i,
    input  logic                        ack_i,
    input  logic                        err_i,
    output logic                        req_o,
    output logic                        stb_o,
    output logic                        cyc_o,
    output logic [fetch_pkg::WADR_W-1:0]  adr_o,
    output logic                        data_ready_o,
    output logic [fetch_pkg::ILEN-1:0]    instr_o,
    output logic                        fetch_err_o,
    output logic                        pc_write_o,
    output logic [fetch_pkg::XLEN-1:0]    new_pc_o
);
    import fetch_pkg::*;

    prefetch_state_t state;
    logic              boot_done;
    logic              vec_irq;
    logic              irq_pend;
    logic [CAUSE_W-1:0] irq_cause_q;
    logic [XLEN-1:0]   rdata_q;
    logic [WADR_W-1:0] vt_word;
    logic              bus_done;
    logic              irq_done;
    logic              irq_take;

    assign vt_word = VTABLE_BASE[XLEN-1:2];

    // Responses only count while this master owns the bus
    assign bus_done = (state != IDLE) && grant_i && (ack_i || err_i);
    assign irq_done = bus_done && (state == VECTOR) && vec_irq;
    assign irq_take = irq_i && (!irq_pend || irq_done);

    // One cycle per bus transaction, held until the slave answers
    assign req_o = (state != IDLE);
    assign stb_o = (state != IDLE);
    assign cyc_o = (state != IDLE);

    assign instr_o  = rdata_q[ILEN-1:0];
    assign new_pc_o = rdata_q;

    // Pending interrupt waits for the next advance
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_pend <= 1'b0;
        end else begin
            if (irq_done) begin
                irq_pend <= 1'b0;
            end
            if (irq_take) begin
                irq_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (irq_take) begin
            irq_cause_q <= irq_cause_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state        <= IDLE;
            boot_done    <= 1'b0;
            vec_irq      <= 1'b0;
            data_ready_o <= 1'b0;
            fetch_err_o  <= 1'b0;
            pc_write_o   <= 1'b0;
        end else begin
            data_ready_o <= 1'b0;
            fetch_err_o  <= 1'b0;
            pc_write_o   <= 1'b0;
            case (state)
                IDLE: begin
                    if (!boot_done) begin
                        state   <= VECTOR;
                        vec_irq <= 1'b0;
                    end else if (advance_i) begin
                        // Interrupt replaces this fetch with a table read
                        state   <= irq_pend ? VECTOR : FETCH;
                        vec_irq <= irq_pend;
                    end
                end
                VECTOR: begin
                    if (bus_done) begin
                        state       <= IDLE;
                        boot_done   <= 1'b1;
                        pc_write_o  <= ack_i;
                        fetch_err_o <= err_i;
                    end
                end
                FETCH: begin
                    if (bus_done) begin
                        state        <= IDLE;
                        data_ready_o <= ack_i;
                        fetch_err_o  <= err_i;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address tracks the next request while idle, frozen during a cycle
    always_ff @(posedge clk_i) begin
        if (state == IDLE) begin
            if (!boot_done) begin
                adr_o <= vt_word;
            end else if (irq_pend) begin
                adr_o <= vt_word + WADR_W'(irq_cause_q);
            end else begin
                adr_o <= pc_i[XLEN-1:2];
            end
        end
        if (bus_done) begin
            rdata_q <= dat_i;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none

module fetch_top #(
    parameter int                         MEM_WORDS   = 256,
    parameter logic [fetch_pkg::XLEN-1:0] VTABLE_BASE = fetch_pkg::VTABLE_BASE
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          fetch_en_i,
    input  logic                          irq_i,
    input  logic [fetch_pkg::CAUSE_W-1:0] irq_cause_i,
    input  logic                          data_req_i,
    input  logic                          data_stb_i,
    input  logic                          data_we_i,
    input  logic [fetch_pkg::WADR_W-1:0]  data_adr_i,
    input  logic [fetch_pkg::XLEN-1:0]    data_dat_i,
    output logic                          data_grant_o,
    output logic                          data_ack_o,
    output logic                          data_err_o,
    output logic [fetch_pkg::XLEN-1:0]    data_dat_o,
    output logic [fetch_pkg::ILEN-1:0]    instr_o,
    output logic                          instr_valid_o,
    output logic [fetch_pkg::XLEN-1:0]    instr_pc_o,
    output logic                          fetch_err_o
);
    import fetch_pkg::*;

    logic              advance;
    logic [XLEN-1:0]   pc;
    logic              pf_ready;
    logic [ILEN-1:0]   pf_instr;
    logic              pf_err;
    logic              pc_write;
    logic [XLEN-1:0]   new_pc;
    logic              pf_req;
    logic              pf_stb;
    logic              pf_cyc;
    logic [WADR_W-1:0] pf_adr;
    logic              pf_grant;
    logic              s_stb;
    logic              s_cyc;
    logic              s_we;
    logic [WADR_W-1:0] s_adr;
    logic [XLEN-1:0]   s_wdat;
    logic [XLEN/8-1:0] s_sel;
    logic [XLEN-1:0]   s_rdat;
    logic              s_ack;
    logic              s_err;

    pc_sequencer u_seq (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fetch_en_i   (fetch_en_i),
        .data_ready_i (pf_ready),
        .instr_i      (pf_instr),
        .fetch_err_i  (pf_err),
        .pc_write_i   (pc_write),
        .new_pc_i     (new_pc),
        .advance_o    (advance),
        .pc_o         (pc),
        .instr_o      (instr_o),
        .instr_valid_o(instr_valid_o),
        .instr_pc_o   (instr_pc_o),
        .fetch_err_o  (fetch_err_o)
    );

    fetch_prefetch #(
        .VTABLE_BASE(VTABLE_BASE)
    ) u_prefetch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .advance_i   (advance),
        .pc_i        (pc),
        .irq_i       (irq_i),
        .irq_cause_i (irq_cause_i),
        .grant_i     (pf_grant),
        .dat_i       (s_rdat),
        .ack_i       (s_ack),
        .err_i       (s_err),
        .req_o       (pf_req),
        .stb_o       (pf_stb),
        .cyc_o       (pf_cyc),
        .adr_o       (pf_adr),
        .data_ready_o(pf_ready),
        .instr_o     (pf_instr),
        .fetch_err_o (pf_err),
        .pc_write_o  (pc_write),
        .new_pc_o    (new_pc)
    );

    // Classic bus, a strobe only counts inside its cycle
    wb_arbiter u_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .m0_req_i  (pf_req),
        .m0_stb_i  (pf_stb && pf_cyc),
        .m0_adr_i  (pf_adr),
        .m1_req_i  (data_req_i),
        .m1_stb_i  (data_stb_i),
        .m1_we_i   (data_we_i),
        .m1_adr_i  (data_adr_i),
        .m1_dat_i  (data_dat_i),
        .s_ack_i   (s_ack),
        .s_err_i   (s_err),
        .m0_grant_o(pf_grant),
        .m1_grant_o(data_grant_o),
        .s_stb_o   (s_stb),
        .s_cyc_o   (s_cyc),
        .s_we_o    (s_we),
        .s_adr_o   (s_adr),
        .s_dat_o   (s_wdat),
        .s_sel_o   (s_sel)
    );

    wb_imem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .stb_i  (s_stb),
        .cyc_i  (s_cyc),
        .we_i   (s_we),
        .adr_i  (s_adr),
        .dat_i  (s_wdat),
        .sel_i  (s_sel),
        .dat_o  (s_rdat),
        .ack_o  (s_ack),
        .err_o  (s_err)
    );

    // Data port only sees answers to its own cycles
    assign data_ack_o = s_ack && data_grant_o;
    assign data_err_o = s_err && data_grant_o;
    assign data_dat_o = s_rdat;

endmodule

`default_nettype wire

// File: source/pc_sequencer.sv
`default_nettype none

module pc_sequencer (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     fetch_en_i,
    input  logic                     data_ready_i,
    input  logic [fetch_pkg::ILEN-1:0] instr_i,
    input  logic                     fetch_err_i,
    input  logic                     pc_write_i,
    input  logic [fetch_pkg::XLEN-1:0] new_pc_i,
    output logic                     advance_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::ILEN-1:0] instr_o,
    output logic                     instr_valid_o,
    output logic [fetch_pkg::XLEN-1:0] instr_pc_o,
    output logic                     fetch_err_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            pc_valid;
    logic            busy;
    logic            done;

    // Any prefetch response closes the outstanding request
    assign done = data_ready_i || fetch_err_i || pc_write_i;

    // pc holds still until the fetch it addressed is delivered
    assign pc_o          = pc_q;
    assign instr_pc_o    = pc_q;
    assign instr_o       = instr_i;
    assign instr_valid_o = data_ready_i;
    assign fetch_err_o   = fetch_err_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q      <= '0;
            pc_valid  <= 1'b0;
            busy      <= 1'b0;
            advance_o <= 1'b0;
        end else begin
            advance_o <= 1'b0;

            if (pc_write_i) begin
                pc_q     <= new_pc_i;
                pc_valid <= 1'b1;
            end else if (data_ready_i || fetch_err_i) begin
                // Errors step too, so a bad word is skipped
                pc_q <= pc_q + XLEN'(4);
            end

            // Nothing is issued until the reset vector has loaded pc
            if (done) begin
                busy <= 1'b0;
            end else if (fetch_en_i && pc_valid && !busy) begin
                advance_o <= 1'b1;
                busy      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/wb_arbiter.sv
`default_nettype none

module wb_arbiter (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         m0_req_i,
    input  logic                         m0_stb_i,
    input  logic [fetch_pkg::WADR_W-1:0]   m0_adr_i,
    input  logic                         m1_req_i,
    input  logic                         m1_stb_i,
    input  logic                         m1_we_i,
    input  logic [fetch_pkg::WADR_W-1:0]   m1_adr_i,
    input  logic [fetch_pkg::XLEN-1:0]     m1_dat_i,
    input  logic                         s_ack_i,
    input  logic                         s_err_i,
    output logic                         m0_grant_o,
    output logic                         m1_grant_o,
    output logic                         s_stb_o,
    output logic                         s_cyc_o,
    output logic                         s_we_o,
    output logic [fetch_pkg::WADR_W-1:0]   s_adr_o,
    output logic [fetch_pkg::XLEN-1:0]     s_dat_o,
    output logic [fetch_pkg::XLEN/8-1:0]   s_sel_o
);
    import fetch_pkg::*;

    logic [1:0] grant_q;
    logic       prio_m1;
    logic       active;

    assign m0_grant_o = grant_q[0];
    assign m1_grant_o = grant_q[1];

    // A cycle lasts as long as the owner keeps its request up
    assign active = (grant_q[0] && m0_req_i) || (grant_q[1] && m1_req_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            grant_q <= 2'b00;
            prio_m1 <= 1'b0;
        end else if (active) begin
            // Whoever just finished yields priority to the other
            if (s_ack_i || s_err_i) begin
                prio_m1 <= grant_q[0];
            end
        end else if (m0_req_i && (!m1_req_i || !prio_m1)) begin
            grant_q <= 2'b01;
        end else if (m1_req_i) begin
            grant_q <= 2'b10;
        end else begin
            grant_q <= 2'b00;
        end
    end

    // Slave side mux, master 0 only ever reads
    assign s_cyc_o = active;
    assign s_stb_o = (grant_q[0] && m0_stb_i) || (grant_q[1] && m1_stb_i);
    assign s_we_o  = grant_q[1] && m1_we_i;
    assign s_adr_o = grant_q[1] ? m1_adr_i : m0_adr_i;
    assign s_dat_o = grant_q[1] ? m1_dat_i : '0;
    assign s_sel_o = {(XLEN/8){1'b1}};

endmodule

`default_nettype wire

// File: source/wb_imem.sv
`default_nettype none

module wb_imem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       stb_i,
    input  logic                       cyc_i,
    input  logic                       we_i,
    input  logic [fetch_pkg::WADR_W-1:0] adr_i,
    input  logic [fetch_pkg::XLEN-1:0]   dat_i,
    input  logic [fetch_pkg::XLEN/8-1:0] sel_i,
    output logic [fetch_pkg::XLEN-1:0]   dat_o,
    output logic                       ack_o,
    output logic                       err_o
);
    import fetch_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [XLEN-1:0] mem [MEM_WORDS];
    logic            in_range;
    logic            start;
    logic [AW-1:0]   idx;

    assign in_range = (adr_i < WADR_W'(MEM_WORDS));
    assign idx      = adr_i[AW-1:0];

    // First cycle of a strobe, the previous answer blocks a repeat
    assign start = stb_i && cyc_i && !ack_o && !err_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= start && in_range;
            err_o <= start && !in_range;
        end
    end

    // Only whole-word writes, lane masks are not supported
    always_ff @(posedge clk_i) begin
        if (start && in_range) begin
            if (we_i && (&sel_i)) begin
                mem[idx] <= dat_i;
            end
            dat_o <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: test/fetch_chk.sv
`default_nettype none

module fetch_chk #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         instr_valid_i,
    input  logic                         fetch_err_i,
    input  logic                         m0_req_i,
    input  logic                         m0_stb_i,
    input  logic                         m0_grant_i,
    input  logic                         m1_grant_i,
    input  logic                         s_stb_i,
    input  logic                         s_cyc_i,
    input  logic                         s_ack_i,
    input  logic                         s_err_i,
    input  logic [fetch_pkg::WADR_W-1:0] s_adr_i,
    input  logic                         data_ack_i
);
    import fetch_pkg::*;

    logic stb_q;
    logic start;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            stb_q <= 1'b0;
        end else begin
            stb_q <= s_stb_i && s_cyc_i;
        end
    end

    // New strobe on the slave, low in the cycle before
    assign start = s_stb_i && s_cyc_i && !stb_q;

    a_valid_err_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(instr_valid_i && fetch_err_i));

    a_single_grant: assert property (@(posedge clk_i) disable iff (reset_i)
        !(m0_grant_i && m1_grant_i));

    // Memory answers exactly one cycle after a new strobe
    a_ack_after_stb: assert property (@(posedge clk_i) disable iff (reset_i)
        start |=> (s_ack_i ^ s_err_i));

    // No answer without a fresh strobe just before, so never two in a row
    a_ack_has_stb: assert property (@(posedge clk_i) disable iff (reset_i)
        (s_ack_i || s_err_i) |-> $past(start));

    a_err_range: assert property (@(posedge clk_i) disable iff (reset_i)
        s_err_i |-> ($past(s_adr_i) >= WADR_W'(MEM_WORDS)));

    a_reset_quiet: assert property (@(posedge clk_i)
        reset_i |=> (!instr_valid_i && !fetch_err_i && !m0_req_i && !m0_stb_i
                     && !s_stb_i && !s_cyc_i && !data_ack_i));

endmodule

`default_nettype wire

// File: test/fetch_tb.sv
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int VT_WORD     = 248;
    localparam int PROG_WORDS  = 80;
    localparam int GRANT_LIMIT = 8;
    localparam int WAIT_LIMIT  = 400;
    // About 180 bus accesses plus 40 fetches, with wide margin
    localparam int WATCHDOG_CYCLES = 4000;

    logic                clk_i = 1'b0;
    logic                reset_i;
    logic                fetch_en_i;
    logic                irq_i;
    logic [CAUSE_W-1:0]  irq_cause_i;
    logic                data_req_i;
    logic                data_stb_i;
    logic                data_we_i;
    logic [WADR_W-1:0]   data_adr_i;
    logic [XLEN-1:0]     data_dat_i;
    logic                data_grant_o;
    logic                data_ack_o;
    logic                data_err_o;
    logic [XLEN-1:0]     data_dat_o;
    logic [ILEN-1:0]     instr_o;
    logic                instr_valid_o;
    logic [XLEN-1:0]     instr_pc_o;
    logic                fetch_err_o;

    logic [XLEN-1:0] model [MEM_WORDS];
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] first_pc;
    logic [XLEN-1:0] last_err_pc;
    logic [XLEN-1:0] irq_handler;
    logic            got_first;
    logic            irq_armed;
    logic            irq_late;
    int              instr_count = 0;
    int              err_count = 0;
    int              checks = 0;
    int              errors = 0;
    int              tests = 0;

    fetch_top #(
        .MEM_WORDS(MEM_WORDS)
    ) dut0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .fetch_en_i   (fetch_en_i),
        .irq_i        (irq_i),
        .irq_cause_i  (irq_cause_i),
        .data_req_i   (data_req_i),
        .data_stb_i   (data_stb_i),
        .data_we_i    (data_we_i),
        .data_adr_i   (data_adr_i),
        .data_dat_i   (data_dat_i),
        .data_grant_o (data_grant_o),
        .data_ack_o   (data_ack_o),
        .data_err_o   (data_err_o),
        .data_dat_o   (data_dat_o),
        .instr_o      (instr_o),
        .instr_valid_o(instr_valid_o),
        .instr_pc_o   (instr_pc_o),
        .fetch_err_o  (fetch_err_o)
    );

    bind fetch_top fetch_chk #(
        .MEM_WORDS(MEM_WORDS)
    ) u_chk (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_valid_i(instr_valid_o),
        .fetch_err_i  (fetch_err_o),
        .m0_req_i     (pf_req),
        .m0_stb_i     (pf_stb),
        .m0_grant_i   (pf_grant),
        .m1_grant_i   (data_grant_o),
        .s_stb_i      (s_stb),
        .s_cyc_i      (s_cyc),
        .s_ack_i      (s_ack),
        .s_err_i      (s_err),
        .s_adr_i      (s_adr),
        .data_ack_i   (data_ack_o)
    );

    always #50 clk_i = ~clk_i;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // Reference model of the instruction stream, sampled mid-cycle
    always @(negedge clk_i) begin
        if (!reset_i && (instr_valid_o || fetch_err_o)) begin
            // At most one sequential word may still arrive before the handler
            if (irq_armed) begin
                if (instr_pc_o == irq_handler || irq_late) begin
                    exp_pc = irq_handler;
                    irq_armed = 1'b0;
                end else begin
                    irq_late = 1'b1;
                end
            end
            if (!got_first) begin
                first_pc = instr_pc_o;
                got_first = 1'b1;
            end
            checks++;
            assert (instr_pc_o == exp_pc) else begin
                errors++;
                $display("Fail t=%0t instr_pc_o expected %h got %h", $time, exp_pc, instr_pc_o);
            end
            if (instr_valid_o) begin
                instr_count++;
                checks++;
                assert (instr_pc_o < XLEN'(MEM_WORDS * 4)
                        && instr_o == model[instr_pc_o[9:2]]) else begin
                    errors++;
                    $display("Fail t=%0t instr_o expected %h got %h", $time,
                             model[instr_pc_o[9:2]], instr_o);
                end
            end else begin
                err_count++;
                last_err_pc = instr_pc_o;
                checks++;
                assert (instr_pc_o >= XLEN'(MEM_WORDS * 4)) else begin
                    errors++;
                    $display("Fetch error reported at %h, inside memory", instr_pc_o);
                end
            end
            exp_pc = exp_pc + 32'd4;
        end
    end

    task automatic bus_access(input logic we, input int word, input logic [XLEN-1:0] wdat,
                              output logic [XLEN-1:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk_i);
        data_req_i <= 1'b1;
        data_stb_i <= 1'b1;
        data_we_i  <= we;
        data_adr_i <= WADR_W'(word);
        data_dat_i <= wdat;
        @(negedge clk_i);
        while (!data_grant_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        checks++;
        assert (waited <= GRANT_LIMIT) else begin
            errors++;
            $display("Fail t=%0t data_grant_o wait expected <= %0d got %0d", $time,
                     GRANT_LIMIT, waited);
        end
        while (!data_ack_o && !data_err_o && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        checks++;
        assert (data_ack_o) else begin
            errors++;
            $display("Data port cycle to word %0d ended without an ack", word);
        end
        rdat = data_dat_o;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_stb_i <= 1'b0;
        data_we_i  <= 1'b0;
    endtask

    task automatic write_word(input int word, input logic [XLEN-1:0] value);
        logic [XLEN-1:0] unused_rd;
        model[word] = value;
        bus_access(1'b1, word, value, unused_rd);
    endtask

    task automatic read_check(input int word);
        logic [XLEN-1:0] rd;
        bus_access(1'b0, word, '0, rd);
        checks++;
        assert (rd == model[word]) else begin
            errors++;
            $display("Fail t=%0t data_dat_o expected %h got %h", $time, model[word], rd);
        end
    endtask

    task automatic wait_instrs(input int target);
        int waited;
        waited = 0;
        while (instr_count < target && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (instr_count < target) begin
            errors++;
            $display("Instruction stream stalled at %0d of %0d", instr_count, target);
        end
    endtask

    task automatic pulse_irq(input int cause);
        irq_handler = model[VT_WORD + cause];
        irq_late = 1'b0;
        irq_armed = 1'b1;
        @(posedge clk_i);
        irq_i       <= 1'b1;
        irq_cause_i <= CAUSE_W'(cause);
        @(posedge clk_i);
        irq_i <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i    <= 1'b1;
        fetch_en_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial begin
        int i;
        int waited;
        logic [XLEN-1:0] rd;
        void'($urandom(44387));
        got_first = 1'b1;
        irq_armed = 1'b0;
        irq_late = 1'b0;
        exp_pc = '0;
        reset_i     <= 1'b1;
        fetch_en_i  <= 1'b0;
        irq_i       <= 1'b0;
        irq_cause_i <= '0;
        data_req_i  <= 1'b0;
        data_stb_i  <= 1'b0;
        data_we_i   <= 1'b0;
        data_adr_i  <= '0;
        data_dat_i  <= '0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;

        // Program words, then the table with reset, irq 3 and irq 6 targets
        for (i = 0; i < PROG_WORDS; i++) begin
            write_word(i, $urandom);
        end
        for (i = 0; i < 8; i++) begin
            write_word(VT_WORD + i, 32'h0000_0100 + 32'(i * 16));
        end
        write_word(VT_WORD, 32'h0000_0020);
        write_word(VT_WORD + 3, 32'h0000_0080);
        write_word(VT_WORD + 6, 32'h0000_03f0);
        for (i = 0; i < PROG_WORDS; i++) begin
            read_check(i);
        end
        for (i = 0; i < 8; i++) begin
            read_check(VT_WORD + i);
        end
        end_test("program load");

        apply_reset();
        exp_pc = model[VT_WORD];
        got_first = 1'b0;
        fetch_en_i <= 1'b1;
        wait_instrs(instr_count + 1);
        checks++;
        assert (got_first && first_pc == model[VT_WORD]) else begin
            errors++;
            $display("Fail t=%0t instr_pc_o expected %h got %h", $time, model[VT_WORD], first_pc);
        end
        end_test("reset vector");

        wait_instrs(instr_count + 8);
        end_test("sequential fetch");

        pulse_irq(3);
        waited = 0;
        while (irq_armed && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (irq_armed) begin
            errors++;
            $display("No instruction came from the irq 3 handler");
        end
        wait_instrs(instr_count + 4);
        end_test("interrupt redirect");

        // Words 72 and up are never fetched, so writes there are safe
        for (i = 72; i < PROG_WORDS; i++) begin
            read_check(i);
            write_word(i, $urandom);
            bus_access(1'b0, VT_WORD, '0, rd);
        end
        wait_instrs(instr_count + 4);
        end_test("contention");

        pulse_irq(6);
        waited = 0;
        while (err_count == 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_i);
        end
        checks++;
        assert (err_count > 0 && last_err_pc == XLEN'(MEM_WORDS * 4)) else begin
            errors++;
            $display("Fail t=%0t fetch_err_o pc expected %h got %h", $time,
                     XLEN'(MEM_WORDS * 4), last_err_pc);
        end
        @(posedge clk_i);
        fetch_en_i <= 1'b0;
        repeat (10) @(posedge clk_i);
        end_test("bus error");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
